// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = aes_inv_round_unit_tb
FILELIST  = aes_inv_round_unit.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== aes_inv_round_unit.f ====
+incdir+verilog
verilog/aes_types_pkg.sv
verilog/aes_cfg_pkg.sv
verilog/inv_sbox.sv
verilog/inv_mix_columns.sv
verilog/aes_key_regs.sv
verilog/aes_inv_round.sv
verilog/aes_inv_round_unit.sv
sim/aes_inv_round_checker.sv
sim/aes_inv_round_sva.sv
sim/aes_inv_round_unit_tb.sv

// ==== sim/aes_inv_round_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aes_inv_round_checker (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       cfg_write,
        input  aes_cfg_pkg::aes_cfg_addr_t cfg_addr,
        input  aes_types_pkg::aes_word_t   cfg_data,
        input  logic                       in_valid,
        input  aes_types_pkg::aes_state_t  in_state,
        input  logic                       out_valid,
        input  aes_types_pkg::aes_state_t  out_state,
        output int                         error_count,
        output int                         check_count,
        output int                         pending
);

        // expected result and the cycle in which its input was sampled.
        typedef struct packed {
                aes_types_pkg::aes_state_t state;
                logic [31:0]               cycle;
        } expect_t;

        aes_types_pkg::aes_byte_t    inv_tab [0:255];
        aes_types_pkg::aes_byte_t    coef [0:3];
        aes_cfg_pkg::aes_round_cfg_t mirror;
        expect_t                     expect_q [$];
        expect_t                     entry;
        logic [31:0]                 cycle;

        // carry-less product reduced modulo x^8 + x^4 + x^3 + x + 1.
        function automatic aes_types_pkg::aes_byte_t gf_mul(
                input aes_types_pkg::aes_byte_t a,
                input aes_types_pkg::aes_byte_t b
        );
                logic [14:0] p;
                p = '0;
                for (int i = 0; i < 8; i++) begin
                        if (b[i]) begin
                                p = p ^ (15'(a) << i);
                        end
                end
                for (int i = 14; i >= 8; i--) begin
                        if (p[i]) begin
                                p = p ^ (15'h11b << (i - 8));
                        end
                end
                return p[7:0];
        endfunction

        // the forward S-box takes the field inverse by search and then the affine map.
        function automatic aes_types_pkg::aes_byte_t fwd_sbox(input aes_types_pkg::aes_byte_t a);
                aes_types_pkg::aes_byte_t inv;
                aes_types_pkg::aes_byte_t r;
                inv = 8'h00;
                for (int b = 1; b < 256; b++) begin
                        if (gf_mul(a, 8'(b)) == 8'h01) begin
                                inv = 8'(b);
                        end
                end
                r = inv ^ 8'h63;
                for (int k = 1; k < 5; k++) begin
                        r = r ^ ((inv << k) | (inv >> (8 - k)));
                end
                return r;
        endfunction

        function automatic aes_types_pkg::aes_state_t ref_round(
                input aes_types_pkg::aes_state_t   s,
                input aes_cfg_pkg::aes_round_cfg_t cfg
        );
                aes_types_pkg::aes_byte_t  b [0:15];
                aes_types_pkg::aes_byte_t  m;
                aes_types_pkg::aes_state_t r;
                // byte (row w, column c) moves right to column (c + w) mod 4.
                for (int c = 0; c < 4; c++) begin
                        for (int w = 0; w < 4; w++) begin
                                b[4 * ((c + w) % 4) + w] = inv_tab[s[127 - 8 * (4 * c + w) -: 8]];
                        end
                end
                for (int i = 0; i < 16; i++) begin
                        b[i] = b[i] ^ cfg.key[127 - 8 * i -: 8];
                        r[127 - 8 * i -: 8] = b[i];
                end
                if (!cfg.last_round) begin
                        for (int c = 0; c < 4; c++) begin
                                for (int w = 0; w < 4; w++) begin
                                        m = 8'h00;
                                        for (int k = 0; k < 4; k++) begin
                                                m = m ^ gf_mul(coef[k], b[4 * c + (w + k) % 4]);
                                        end
                                        r[127 - 8 * (4 * c + w) -: 8] = m;
                                end
                        end
                end
                return r;
        endfunction

        // a result seen at the falling edge is what the next rising edge samples.
        task automatic compare_result();
                expect_t e;
                e = expect_q.pop_front();
                check_count = check_count + 1;
                if (cycle + 1 - e.cycle != `AES_PIPE_DEPTH) begin
                        $display("error at %0t: out_valid came %0d cycles after in_valid",
                                 $time, cycle + 1 - e.cycle);
                        error_count = error_count + 1;
                end
                if (out_state !== e.state) begin
                        $display("error at %0t: out_state expected %h actual %h",
                                 $time, e.state, out_state);
                        error_count = error_count + 1;
                end
        endtask

        // ********************************************************************
        // inputs are taken at the rising edge, outputs at the falling edge
        // ********************************************************************

        initial begin
                coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
                for (int v = 0; v < 256; v++) begin
                        inv_tab[fwd_sbox(8'(v))] = 8'(v);
                end
                error_count = 0;
                check_count = 0;
                pending     = 0;
                cycle       = '0;
                mirror      = '0;
                forever begin
                        @(posedge clk);
                        cycle = cycle + 1;
                        if (reset) begin
                                mirror = '0;
                                expect_q.delete();
                        end else begin
                                // a block sampled with a write still sees the old settings.
                                if (in_valid) begin
                                        entry.state = ref_round(in_state, mirror);
                                        entry.cycle = cycle;
                                        expect_q.push_back(entry);
                                end
                                if (cfg_write) begin
                                        case (cfg_addr)
                                                `AES_ADDR_KEY0: mirror.key[127:96] = cfg_data;
                                                `AES_ADDR_KEY1: mirror.key[95:64]  = cfg_data;
                                                `AES_ADDR_KEY2: mirror.key[63:32]  = cfg_data;
                                                `AES_ADDR_KEY3: mirror.key[31:0]   = cfg_data;
                                                `AES_ADDR_CTRL: mirror.last_round  = cfg_data[0];
                                                default: ;
                                        endcase
                                end
                        end
                        pending = expect_q.size();
                        @(negedge clk);
                        if (reset) begin
                                if (out_valid !== 1'b0) begin
                                        $display("error at %0t: out_valid is high during reset",
                                                 $time);
                                        error_count = error_count + 1;
                                end
                        end else begin
                                while (expect_q.size() != 0 &&
                                       cycle + 1 - expect_q[0].cycle > `AES_PIPE_DEPTH) begin
                                        $display("error at %0t: no result for block of cycle %0d",
                                                 $time, expect_q[0].cycle);
                                        error_count = error_count + 1;
                                        entry = expect_q.pop_front();
                                end
                                if (out_valid && expect_q.size() == 0) begin
                                        $display("error at %0t: out_valid with no block in flight",
                                                 $time);
                                        error_count = error_count + 1;
                                end else if (out_valid) begin
                                        compare_result();
                                end
                        end
                        pending = expect_q.size();
                end
        end

endmodule

`default_nettype wire

// ==== sim/aes_inv_round_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aes_inv_round_sva (
        input logic                      clk,
        input logic                      reset,
        input logic                      in_valid,
        input logic                      out_valid,
        input aes_types_pkg::aes_state_t out_state
);

        // the valid pipeline is cleared by the reset edge itself.
        out_valid_low_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
                else $error("out_valid high in the cycle after a reset edge");

        out_valid_latency: assert property (@(posedge clk) disable iff (reset)
                out_valid == $past(in_valid, `AES_PIPE_DEPTH))
                else $error("out_valid does not follow in_valid by the pipeline depth");

        out_state_known: assert property (@(posedge clk) disable iff (reset)
                out_valid |-> !$isunknown(out_state))
                else $error("out_state has unknown bits while out_valid is high");

endmodule

`default_nettype wire

// ==== sim/aes_inv_round_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aes_inv_round_unit_tb;

        localparam int          RESET_CYCLES = 16;
        localparam int          GAP_BLOCKS   = 32;
        // each test is counted with its drain and every gap at its longest of three idle cycles.
        localparam int          RUN_CYCLES   = RESET_CYCLES + 8 + 24 + 76 + 28 + 8 + 4 * GAP_BLOCKS;
        localparam int          MARGIN       = 200;
        localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

        logic                       clk;
        logic                       reset;
        logic                       cfg_write;
        aes_cfg_pkg::aes_cfg_addr_t cfg_addr;
        aes_types_pkg::aes_word_t   cfg_data;
        logic                       in_valid;
        aes_types_pkg::aes_state_t  in_state;
        logic                       out_valid;
        aes_types_pkg::aes_state_t  out_state;
        int                         error_count;
        int                         check_count;
        int                         pending;
        int                         sent_count;
        int                         errors_before;
        int                         checks_before;
        logic [31:0]                lfsr;

        aes_inv_round_unit aes_inv_round_unit_inst (
                .clk       (clk),
                .reset     (reset),
                .cfg_write (cfg_write),
                .cfg_addr  (cfg_addr),
                .cfg_data  (cfg_data),
                .in_valid  (in_valid),
                .in_state  (in_state),
                .out_valid (out_valid),
                .out_state (out_state)
        );

        aes_inv_round_checker aes_inv_round_checker_inst (
                .clk         (clk),
                .reset       (reset),
                .cfg_write   (cfg_write),
                .cfg_addr    (cfg_addr),
                .cfg_data    (cfg_data),
                .in_valid    (in_valid),
                .in_state    (in_state),
                .out_valid   (out_valid),
                .out_state   (out_state),
                .error_count (error_count),
                .check_count (check_count),
                .pending     (pending)
        );

        bind aes_inv_round_unit aes_inv_round_sva aes_inv_round_sva_inst (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .out_valid (out_valid),
                .out_state (out_state)
        );

        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
        endfunction

        // each bit taken steps the LFSR once and the newest bit lands in bit 0.
        function automatic logic [127:0] random_bits(input int n);
                logic [127:0] r;
                r = '0;
                for (int i = 0; i < n; i++) begin
                        r    = {r[126:0], lfsr[0]};
                        lfsr = lfsr_step(lfsr);
                end
                return r;
        endfunction

        task automatic step(input logic wr, input aes_cfg_pkg::aes_cfg_addr_t addr,
                            input aes_types_pkg::aes_word_t data, input logic vld,
                            input aes_types_pkg::aes_state_t st);
                @(negedge clk);
                cfg_write = wr;
                cfg_addr  = addr;
                cfg_data  = data;
                in_valid  = vld;
                in_state  = st;
                if (vld) begin
                        sent_count = sent_count + 1;
                end
        endtask

        task automatic finish_test(input string name);
                step(1'b0, '0, '0, 1'b0, '0);
                wait (pending == 0);
                step(1'b0, '0, '0, 1'b0, '0);
                $display("test %s: %0d blocks checked, %0d errors", name,
                         check_count - checks_before, error_count - errors_before);
                checks_before = check_count;
                errors_before = error_count;
        endtask

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        initial begin
                repeat (RUN_CYCLES + MARGIN) @(posedge clk);
                $display("timeout: the tests did not finish within %0d cycles",
                         RUN_CYCLES + MARGIN);
                $display("*** TEST FAILED ***");
                $finish;
        end

        // ********************************************************************
        // test sequence
        // ********************************************************************

        initial begin
                aes_types_pkg::aes_word_t  w;
                aes_types_pkg::aes_state_t st;
                int                        gap;
                reset         = 1'b1;
                cfg_write     = 1'b0;
                cfg_addr      = '0;
                cfg_data      = '0;
                in_valid      = 1'b0;
                in_state      = '0;
                lfsr          = 32'h793b0a2e;
                sent_count    = 0;
                errors_before = 0;
                checks_before = 0;
                repeat (RESET_CYCLES) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;

                st = random_bits(128);
                step(1'b0, '0, '0, 1'b1, st);
                finish_test("reset state");

                // sixteen blocks of sixteen bytes cover every S-box input once.
                step(1'b1, `AES_ADDR_CTRL, 32'd1, 1'b0, '0);
                for (int k = 0; k < 16; k++) begin
                        for (int i = 0; i < 16; i++) begin
                                st[127 - 8 * i -: 8] = 8'(16 * k + i);
                        end
                        step(1'b0, '0, '0, 1'b1, st);
                end
                finish_test("exhaustive inverse S-box");

                for (int k = 0; k < 4; k++) begin
                        w = 32'(random_bits(32));
                        step(1'b1, aes_cfg_pkg::aes_cfg_addr_t'(k), w, 1'b0, '0);
                end
                step(1'b1, `AES_ADDR_CTRL, 32'd0, 1'b0, '0);
                for (int k = 0; k < 64; k++) begin
                        st = random_bits(128);
                        step(1'b0, '0, '0, 1'b1, st);
                end
                finish_test("full rounds back to back");

                // key and mode writes land with blocks, between them and off the map.
                for (int i = 0; i < 16; i++) begin
                        st = random_bits(128);
                        w  = 32'(random_bits(32));
                        case (i % 4)
                                0: step(1'b1, aes_cfg_pkg::aes_cfg_addr_t'((i / 4) % 4), w,
                                        1'b1, st);
                                1: step(1'b1, aes_cfg_pkg::aes_cfg_addr_t'(5 + (i / 4) % 3), w,
                                        1'b1, st);
                                2: step(1'b1, `AES_ADDR_CTRL, w, 1'b1, st);
                                default: step(1'b1, aes_cfg_pkg::aes_cfg_addr_t'((i / 4 + 1) % 4), w,
                                              1'b0, '0);
                        endcase
                end
                finish_test("configuration change in flight");

                step(1'b1, `AES_ADDR_CTRL, 32'd0, 1'b0, '0);
                for (int k = 0; k < GAP_BLOCKS; k++) begin
                        gap = int'(random_bits(2));
                        repeat (gap) step(1'b0, '0, '0, 1'b0, '0);
                        st = random_bits(128);
                        step(1'b0, '0, '0, 1'b1, st);
                end
                finish_test("gaps in the input stream");

                if (check_count != sent_count) begin
                        $display("%0d blocks were sent but %0d results were checked",
                                 sent_count, check_count);
                end
                $display("summary: %0d blocks sent, %0d checked, %0d errors",
                         sent_count, check_count, error_count);
                if (error_count == 0 && check_count == sent_count) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== verilog/aes_cfg_pkg.sv ====
`default_nettype none

`include "aes_settings.svh"

package aes_cfg_pkg;

        // address on the configuration port.
        typedef logic [`AES_CFG_ADDR_W-1:0] aes_cfg_addr_t;

        // everything one block needs to run its round.
        // it travels with the block through the pipeline.
        typedef struct packed {
                aes_types_pkg::aes_state_t key;
                logic                      last_round;
        } aes_round_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/aes_inv_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aes_inv_round (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        in_valid,
        input  aes_types_pkg::aes_state_t   in_state,
        input  aes_cfg_pkg::aes_round_cfg_t round_cfg,
        output logic                        out_valid,
        output aes_types_pkg::aes_state_t   out_state
);

        aes_types_pkg::aes_state_t   sub_bytes;
        aes_types_pkg::aes_state_t   s1_state;
        aes_cfg_pkg::aes_round_cfg_t s1_cfg;
        aes_types_pkg::aes_state_t   add_key;
        aes_types_pkg::aes_state_t   mixed;
        logic [`AES_PIPE_DEPTH-1:0]  valid_pipe;

        // ********************************************************************
        // stage 1: InvShiftRows and InvSubBytes
        // ********************************************************************

        // row r is rotated right by r, so output byte (r, c) comes
        // from input column (c - r) mod 4 of the same row.
        for (genvar c = 0; c < 4; c++) begin : g_col
                for (genvar r = 0; r < 4; r++) begin : g_row
                        localparam int SRC = 4 * ((c - r + 4) % 4) + r;
                        localparam int DST = 4 * c + r;

                        inv_sbox inv_sbox_inst (
                                .x (in_state[127 - 8 * SRC -: 8]),
                                .y (sub_bytes[127 - 8 * DST -: 8])
                        );
                end
        end

        // the configuration is captured with the data, so a later
        // register write does not touch a block already in flight.
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        s1_state <= sub_bytes;
                        s1_cfg   <= round_cfg;
                end
        end

        // ********************************************************************
        // stage 2: AddRoundKey and InvMixColumns
        // ********************************************************************

        assign add_key = s1_state ^ s1_cfg.key;

        inv_mix_columns inv_mix_columns_inst (
                .state_in  (add_key),
                .state_out (mixed)
        );

        // out_state keeps its value between results.
        always_ff @(posedge clk) begin
                if (valid_pipe[0]) begin
                        out_state <= s1_cfg.last_round ? add_key : mixed;
                end
        end

        // valid bits shift alongside the data registers.
        always_ff @(posedge clk) begin
                if (reset) begin
                        valid_pipe <= '0;
                end else begin
                        valid_pipe <= {valid_pipe[`AES_PIPE_DEPTH-2:0], in_valid};
                end
        end

        assign out_valid = valid_pipe[`AES_PIPE_DEPTH-1];

endmodule

`default_nettype wire

// ==== verilog/aes_inv_round_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round_unit (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       cfg_write,
        input  aes_cfg_pkg::aes_cfg_addr_t cfg_addr,
        input  aes_types_pkg::aes_word_t   cfg_data,
        input  logic                       in_valid,
        input  aes_types_pkg::aes_state_t  in_state,
        output logic                       out_valid,
        output aes_types_pkg::aes_state_t  out_state
);

        aes_cfg_pkg::aes_round_cfg_t round_cfg;

        aes_key_regs aes_key_regs_inst (
                .clk       (clk),
                .reset     (reset),
                .cfg_write (cfg_write),
                .cfg_addr  (cfg_addr),
                .cfg_data  (cfg_data),
                .round_cfg (round_cfg)
        );

        aes_inv_round aes_inv_round_inst (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (in_valid),
                .in_state  (in_state),
                .round_cfg (round_cfg),
                .out_valid (out_valid),
                .out_state (out_state)
        );

endmodule

`default_nettype wire

// ==== verilog/aes_key_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aes_key_regs (
        input  logic                        clk,
        input  logic                        reset,
        input  logic                        cfg_write,
        input  aes_cfg_pkg::aes_cfg_addr_t  cfg_addr,
        input  aes_types_pkg::aes_word_t    cfg_data,
        output aes_cfg_pkg::aes_round_cfg_t round_cfg
);

        aes_types_pkg::aes_word_t key_word [0:3];
        logic                     last_round;

        // writes to addresses outside the map fall through the default.
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < 4; i++) begin
                                key_word[i] <= '0;
                        end
                        last_round <= 1'b0;
                end else if (cfg_write) begin
                        case (cfg_addr)
                                `AES_ADDR_KEY0: key_word[0] <= cfg_data;
                                `AES_ADDR_KEY1: key_word[1] <= cfg_data;
                                `AES_ADDR_KEY2: key_word[2] <= cfg_data;
                                `AES_ADDR_KEY3: key_word[3] <= cfg_data;
                                `AES_ADDR_CTRL: last_round  <= cfg_data[0];
                                default: ;
                        endcase
                end
        end

        assign round_cfg = '{
                key:        {key_word[0], key_word[1], key_word[2], key_word[3]},
                last_round: last_round
        };

endmodule

`default_nettype wire

// ==== verilog/aes_settings.svh ====
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// ****************************************************************************
// register map of the round configuration block
// ****************************************************************************

// width of the configuration address bus.
`define AES_CFG_ADDR_W 3

// KEY0 holds the most significant word of the round key.
`define AES_ADDR_KEY0 3'd0
`define AES_ADDR_KEY1 3'd1
`define AES_ADDR_KEY2 3'd2
`define AES_ADDR_KEY3 3'd3

// bit 0 is the last-round bit, which skips InvMixColumns.
`define AES_ADDR_CTRL 3'd4

// latency of the round datapath in clock cycles.
`define AES_PIPE_DEPTH 2

`endif

// ==== verilog/aes_types_pkg.sv ====
`default_nettype none

package aes_types_pkg;

        // one byte of the cipher state.
        typedef logic [7:0] aes_byte_t;

        // one column of the state or one word of the round key.
        typedef logic [31:0] aes_word_t;

        // the four bytes of a column with element 0 in row 0.
        typedef aes_byte_t [0:3] aes_column_t;

        // the full state has byte 0 in the top bits and runs column by column.
        typedef logic [127:0] aes_state_t;

        // low byte of the field polynomial x^8 + x^4 + x^3 + x + 1.
        localparam aes_byte_t AES_POLY = 8'h1b;

endpackage

`default_nettype wire

// ==== verilog/inv_mix_columns.sv ====
`timescale 1ns/1ps
`default_nettype none

module inv_mix_columns (
        input  aes_types_pkg::aes_state_t state_in,
        output aes_types_pkg::aes_state_t state_out
);

        // multiply by x in GF(2^8).
        function automatic aes_types_pkg::aes_byte_t xtime(input aes_types_pkg::aes_byte_t b);
                return {b[6:0], 1'b0} ^ (b[7] ? aes_types_pkg::AES_POLY : 8'h00);
        endfunction

        // one column times the matrix with rows 0e 0b 0d 09, rotated per row.
        function automatic aes_types_pkg::aes_column_t mix_column(
                input aes_types_pkg::aes_column_t c
        );
                aes_types_pkg::aes_column_t x2;
                aes_types_pkg::aes_column_t x4;
                aes_types_pkg::aes_column_t x8;
                aes_types_pkg::aes_column_t m9;
                aes_types_pkg::aes_column_t m11;
                aes_types_pkg::aes_column_t m13;
                aes_types_pkg::aes_column_t m14;
                aes_types_pkg::aes_column_t r;
                for (int j = 0; j < 4; j++) begin
                        x2[j]  = xtime(c[j]);
                        x4[j]  = xtime(x2[j]);
                        x8[j]  = xtime(x4[j]);
                        m9[j]  = x8[j] ^ c[j];
                        m11[j] = x8[j] ^ x2[j] ^ c[j];
                        m13[j] = x8[j] ^ x4[j] ^ c[j];
                        m14[j] = x8[j] ^ x4[j] ^ x2[j];
                end
                for (int i = 0; i < 4; i++) begin
                        r[i] = m14[i] ^ m11[(i + 1) % 4] ^ m13[(i + 2) % 4] ^ m9[(i + 3) % 4];
                end
                return r;
        endfunction

        // the columns are independent and column 0 sits in the top word.
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        state_out[127 - 32 * c -: 32] = mix_column(state_in[127 - 32 * c -: 32]);
                end
        end

endmodule

`default_nettype wire

// ==== verilog/inv_sbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module inv_sbox (
        input  aes_types_pkg::aes_byte_t x,
        output aes_types_pkg::aes_byte_t y
);

        // constant added by the inverse affine transform.
        localparam aes_types_pkg::aes_byte_t INV_AFFINE_C = 8'h05;

        aes_types_pkg::aes_byte_t affine;
        aes_types_pkg::aes_byte_t power;
        aes_types_pkg::aes_byte_t product;

        // shift-and-add multiply in GF(2^8).
        function automatic aes_types_pkg::aes_byte_t gf_mul(
                input aes_types_pkg::aes_byte_t a,
                input aes_types_pkg::aes_byte_t b
        );
                aes_types_pkg::aes_byte_t p;
                aes_types_pkg::aes_byte_t m;
                p = '0;
                m = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i]) begin
                                p = p ^ m;
                        end
                        m = {m[6:0], 1'b0} ^ (m[7] ? aes_types_pkg::AES_POLY : 8'h00);
                end
                return p;
        endfunction

        // ********************************************************************
        // inverse affine transform
        // ********************************************************************

        always_comb begin
                for (int i = 0; i < 8; i++) begin
                        affine[i] = x[(i + 2) % 8] ^ x[(i + 5) % 8] ^ x[(i + 7) % 8] ^
                                    INV_AFFINE_C[i];
                end
        end

        // ********************************************************************
        // multiplicative inverse as a^254
        // ********************************************************************

        // a^254 is the product of a^2, a^4 up to a^128.
        // zero maps to zero without a special case.
        always_comb begin
                power   = gf_mul(affine, affine);
                product = power;
                for (int i = 0; i < 6; i++) begin
                        power   = gf_mul(power, power);
                        product = gf_mul(product, power);
                end
        end

        assign y = product;

endmodule

`default_nettype wire
